// File: verilog/regex_pkg.sv
package regex_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int PC_WIDTH       = 8;
    localparam int CHAR_WIDTH     = 8;
    localparam int INSTR_WIDTH    = 16;
    localparam int OPCODE_WIDTH   = 2;
    localparam int OPERAND_WIDTH  = 8;
    // bits between opcode and operand, kept zero by the assembler
    localparam int RESERVED_WIDTH = INSTR_WIDTH - OPCODE_WIDTH - OPERAND_WIDTH;

    // counter queue geometry
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    ////////////////////////////////////////////////////////////
    // instruction set
    ////////////////////////////////////////////////////////////
    typedef enum logic [OPCODE_WIDTH-1:0] {
        MATCH  = 2'd0,
        JUMP   = 2'd1,
        SPLIT  = 2'd2,
        ACCEPT = 2'd3
    } opcode_e;

    // operand is the character for MATCH, the target for JUMP and SPLIT
    typedef struct packed {
        opcode_e                   opcode;
        logic [RESERVED_WIDTH-1:0] reserved;
        logic [OPERAND_WIDTH-1:0]  operand;
    } instr_t;

    // thread packet, to_current low means it waits for the next character
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                to_current;
    } pc_entry_t;

endpackage

// File: verilog/mem_pkg.sv
package mem_pkg;

    // instruction memory word and its address
    localparam int MEM_WIDTH           = 32;
    localparam int MEM_ADDR_WIDTH      = 7;

    // two instructions per word
    // low counter bit picks the half, 0 is bits 15:0
    localparam int INSTR_PER_WORD_LOG2 = 1;
    localparam int SLOT_WIDTH          = MEM_WIDTH >> INSTR_PER_WORD_LOG2;

endpackage

// File: verilog/pc_fifo.sv
module pc_fifo (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           push,
    input  logic [regex_pkg::PC_WIDTH-1:0] push_data,
    output logic                           full,
    input  logic                           pop,
    output logic [regex_pkg::PC_WIDTH-1:0] pop_data,
    output logic                           empty
);
    import regex_pkg::*;

    logic [PC_WIDTH-1:0]       mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;
    logic                      do_push;
    logic                      do_pop;

    // circular pointer step, wraps at the last entry
    function automatic logic [FIFO_PTR_WIDTH-1:0] ptr_inc(
        input logic [FIFO_PTR_WIDTH-1:0] ptr
    );
        if (ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full    = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign empty   = (count == '0);
    // push into a full queue or pop from an empty one is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head is read straight from the array
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/pc_store.sv
module pc_store (
    input  logic                           clk,
    input  logic                           arst_n,
    input  regex_pkg::pc_entry_t           in_pc,
    input  logic                           in_pc_valid,
    output logic                           in_pc_ready,
    input  logic                           cur_is_even_character,
    output logic [regex_pkg::PC_WIDTH-1:0] cur_pc,
    output logic                           cur_pc_valid,
    input  logic                           cur_pc_pop
);
    import regex_pkg::*;

    logic                in_accept;
    logic                to_even;
    logic                even_push;
    logic                odd_push;
    logic                even_pop;
    logic                odd_pop;
    logic                even_full;
    logic                odd_full;
    logic                even_empty;
    logic                odd_empty;
    logic [PC_WIDTH-1:0] even_head;
    logic [PC_WIDTH-1:0] odd_head;

    ////////////////////////////////////////////////////////////
    // input router
    ////////////////////////////////////////////////////////////
    // ready needs room in both queues
    // so ready never depends on the to_current bit
    assign in_pc_ready = !even_full && !odd_full;
    assign in_accept   = in_pc_valid && in_pc_ready;

    // even queue takes current threads on even characters
    // and next threads on odd characters
    assign to_even   = (in_pc.to_current == cur_is_even_character);
    assign even_push = in_accept && to_even;
    assign odd_push  = in_accept && !to_even;

    ////////////////////////////////////////////////////////////
    // current side
    ////////////////////////////////////////////////////////////
    // only the current queue is ever popped
    assign even_pop = cur_pc_pop && cur_is_even_character;
    assign odd_pop  = cur_pc_pop && !cur_is_even_character;

    assign cur_pc       = cur_is_even_character ? even_head : odd_head;
    assign cur_pc_valid = cur_is_even_character ? !even_empty : !odd_empty;

    pc_fifo u_even (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (even_push),
        .push_data (in_pc.pc),
        .full      (even_full),
        .pop       (even_pop),
        .pop_data  (even_head),
        .empty     (even_empty)
    );

    pc_fifo u_odd (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (odd_push),
        .push_data (in_pc.pc),
        .full      (odd_full),
        .pop       (odd_pop),
        .pop_data  (odd_head),
        .empty     (odd_empty)
    );

endmodule

// File: verilog/instr_fetch.sv
module instr_fetch (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [regex_pkg::PC_WIDTH-1:0]      fetch_pc,
    input  logic                                fetch_valid,
    output logic                                fetch_ready,
    output regex_pkg::instr_t                   fetch_instr,
    output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  mem_addr,
    output logic                                mem_valid,
    input  logic [mem_pkg::MEM_WIDTH-1:0]       mem_data,
    input  logic                                mem_ready
);
    import regex_pkg::*;
    import mem_pkg::*;

    logic [INSTR_PER_WORD_LOG2-1:0] half_live;
    logic [INSTR_PER_WORD_LOG2-1:0] half_q;
    logic [INSTR_PER_WORD_LOG2-1:0] half_sel;

    // counter to word address, request passes straight to memory
    assign half_live   = fetch_pc[INSTR_PER_WORD_LOG2-1:0];
    assign mem_addr    = fetch_pc[INSTR_PER_WORD_LOG2 +: MEM_ADDR_WIDTH];
    assign mem_valid   = fetch_valid;
    assign fetch_ready = mem_ready;

    // half of the last accepted request
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            half_q <= '0;
        else if (fetch_valid && mem_ready)
            half_q <= half_live;
    end

    // live bit during a request, otherwise keep pointing at the last half
    assign half_sel = fetch_valid ? half_live : half_q;

    // slice the word, valid in the mem_ready cycle
    assign fetch_instr = instr_t'(mem_data[half_sel * SLOT_WIDTH +: SLOT_WIDTH]);

endmodule

// File: verilog/regex_cpu.sv
module regex_cpu (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             go,
    input  logic [regex_pkg::CHAR_WIDTH-1:0] current_character,
    input  logic [regex_pkg::PC_WIDTH-1:0]   cur_pc,
    input  logic                             cur_pc_valid,
    output logic                             cur_pc_pop,
    output logic [regex_pkg::PC_WIDTH-1:0]   fetch_pc,
    output logic                             fetch_valid,
    input  logic                             fetch_ready,
    input  regex_pkg::instr_t                fetch_instr,
    output regex_pkg::pc_entry_t             out_pc,
    output logic                             out_pc_valid,
    input  logic                             out_pc_ready,
    output logic                             accepts,
    output logic                             busy
);
    import regex_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EMIT_FIRST,
        EMIT_SECOND
    } state_e;

    state_e              state;
    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] pc_inc;
    instr_t              instr_q;
    pc_entry_t           out_q;
    logic                accept_q;
    logic                fetch_done;
    logic                emit_done;
    logic                char_hit;

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////
    // one thread at a time, taken only while go is high
    assign cur_pc_pop = (state == IDLE) && go && cur_pc_valid;

    assign fetch_pc    = pc_q;
    assign fetch_valid = (state == FETCH);
    assign fetch_done  = fetch_valid && fetch_ready;

    assign out_pc       = out_q;
    assign out_pc_valid = (state == EMIT_FIRST) || (state == EMIT_SECOND);
    assign emit_done    = out_pc_valid && out_pc_ready;

    assign accepts = accept_q;
    assign busy    = (state != IDLE);

    assign pc_inc   = pc_q + 1'b1;
    assign char_hit = (fetch_instr.operand == current_character);

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= IDLE;
            accept_q <= 1'b0;
        end
        else
        begin
            // accept is a one cycle pulse
            accept_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (cur_pc_pop)
                        state <= FETCH;
                end
                FETCH:
                begin
                    if (fetch_done)
                    begin
                        case (fetch_instr.opcode)
                            MATCH:       state <= char_hit ? EMIT_FIRST : IDLE;
                            JUMP, SPLIT: state <= EMIT_FIRST;
                            ACCEPT:
                            begin
                                state    <= IDLE;
                                accept_q <= 1'b1;
                            end
                            default:     state <= IDLE;
                        endcase
                    end
                end
                EMIT_FIRST:
                begin
                    // split still owes its target
                    if (emit_done)
                        state <= (instr_q.opcode == SPLIT) ? EMIT_SECOND : IDLE;
                end
                EMIT_SECOND:
                begin
                    if (emit_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // thread and output registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (cur_pc_pop)
            pc_q <= cur_pc;

        if (fetch_done)
        begin
            instr_q <= fetch_instr;
            case (fetch_instr.opcode)
                // a matched thread moves on to the next character
                MATCH:   out_q <= '{pc: pc_inc, to_current: 1'b0};
                JUMP:    out_q <= '{pc: fetch_instr.operand, to_current: 1'b1};
                // fall-through branch goes out first
                SPLIT:   out_q <= '{pc: pc_inc, to_current: 1'b1};
                default: out_q <= out_q;
            endcase
        end
        else if (emit_done && (state == EMIT_FIRST))
        begin
            out_q <= '{pc: instr_q.operand, to_current: 1'b1};
        end
    end

endmodule

// File: verilog/basic_block.sv
module basic_block (
    input  logic                                clk,
    input  logic                                arst_n,
    // threads in
    input  regex_pkg::pc_entry_t                in_pc,
    input  logic                                in_pc_valid,
    output logic                                in_pc_ready,
    // threads out
    output regex_pkg::pc_entry_t                out_pc,
    output logic                                out_pc_valid,
    input  logic                                out_pc_ready,
    // instruction memory
    output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  mem_addr,
    output logic                                mem_valid,
    input  logic [mem_pkg::MEM_WIDTH-1:0]       mem_data,
    input  logic                                mem_ready,
    // character control
    input  logic                                go,
    input  logic                                cur_is_even_character,
    input  logic [regex_pkg::CHAR_WIDTH-1:0]    current_character,
    output logic                                accepts,
    output logic                                running
);
    import regex_pkg::*;

    logic [PC_WIDTH-1:0] cur_pc;
    logic                cur_pc_valid;
    logic                cur_pc_pop;
    logic [PC_WIDTH-1:0] fetch_pc;
    logic                fetch_valid;
    logic                fetch_ready;
    instr_t              fetch_instr;
    logic                cpu_busy;

    // work left on this character, queued or in the engine
    assign running = cur_pc_valid || cpu_busy;

    pc_store u_store (
        .clk                   (clk),
        .arst_n                (arst_n),
        .in_pc                 (in_pc),
        .in_pc_valid           (in_pc_valid),
        .in_pc_ready           (in_pc_ready),
        .cur_is_even_character (cur_is_even_character),
        .cur_pc                (cur_pc),
        .cur_pc_valid          (cur_pc_valid),
        .cur_pc_pop            (cur_pc_pop)
    );

    instr_fetch u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_instr (fetch_instr),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .mem_ready   (mem_ready)
    );

    regex_cpu u_cpu (
        .clk               (clk),
        .arst_n            (arst_n),
        .go                (go),
        .current_character (current_character),
        .cur_pc            (cur_pc),
        .cur_pc_valid      (cur_pc_valid),
        .cur_pc_pop        (cur_pc_pop),
        .fetch_pc          (fetch_pc),
        .fetch_valid       (fetch_valid),
        .fetch_ready       (fetch_ready),
        .fetch_instr       (fetch_instr),
        .out_pc            (out_pc),
        .out_pc_valid      (out_pc_valid),
        .out_pc_ready      (out_pc_ready),
        .accepts           (accepts),
        .busy              (cpu_busy)
    );

endmodule

// File: include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

////////////////////////////////////////////////////////////
// program image, low half of a word is the even counter
////////////////////////////////////////////////////////////
// 0 MATCH 'a'   1 SPLIT 4
// 2 JUMP 5      3 MATCH 'c'
// 4 ACCEPT      5 MATCH 'b'
// 6 ACCEPT      7 JUMP 0
localparam int TB_PROGRAM_WORDS = 4;

localparam logic [mem_pkg::MEM_WIDTH-1:0] TB_PROGRAM [TB_PROGRAM_WORDS] = '{
    32'h8004_0061,
    32'h0063_4005,
    32'h0062_c000,
    32'h4000_c000
};

////////////////////////////////////////////////////////////
// stimulus and expected results
////////////////////////////////////////////////////////////
// even is cur_is_even_character at injection
// rows with to_current low are released by toggling even afterwards
typedef struct packed {
    logic [regex_pkg::PC_WIDTH-1:0]   pc;
    logic                             to_current;
    logic [regex_pkg::CHAR_WIDTH-1:0] character;
    logic                             even;
    logic [1:0]                       n_out;
    regex_pkg::pc_entry_t             exp_first;
    regex_pkg::pc_entry_t             exp_second;
    logic                             exp_accept;
} tb_row_t;

localparam int TB_ROWS = 9;

localparam tb_row_t TB_TABLE [TB_ROWS] = '{
    '{8'd0, 1'b1, 8'h61, 1'b1, 2'd1, '{8'd1, 1'b0}, '{8'd0, 1'b0}, 1'b0},
    '{8'd0, 1'b1, 8'h78, 1'b1, 2'd0, '{8'd0, 1'b0}, '{8'd0, 1'b0}, 1'b0},
    '{8'd1, 1'b1, 8'h61, 1'b1, 2'd2, '{8'd2, 1'b1}, '{8'd4, 1'b1}, 1'b0},
    '{8'd2, 1'b1, 8'h61, 1'b1, 2'd1, '{8'd5, 1'b1}, '{8'd0, 1'b0}, 1'b0},
    '{8'd4, 1'b1, 8'h61, 1'b1, 2'd0, '{8'd0, 1'b0}, '{8'd0, 1'b0}, 1'b1},
    '{8'd5, 1'b0, 8'h62, 1'b1, 2'd1, '{8'd6, 1'b0}, '{8'd0, 1'b0}, 1'b0},
    '{8'd7, 1'b1, 8'h62, 1'b0, 2'd1, '{8'd0, 1'b1}, '{8'd0, 1'b0}, 1'b0},
    '{8'd3, 1'b1, 8'h63, 1'b0, 2'd1, '{8'd4, 1'b0}, '{8'd0, 1'b0}, 1'b0},
    '{8'd6, 1'b1, 8'h63, 1'b0, 2'd0, '{8'd0, 1'b0}, '{8'd0, 1'b0}, 1'b1}
};

`endif

// File: test/tb_basic_block.sv
module tb_basic_block;
    import regex_pkg::*;
    import mem_pkg::*;

    `include "tb_program.svh"

    localparam int READY_TIMEOUT = 50;
    localparam int IDLE_TIMEOUT  = 200;
    localparam int HOLD_CYCLES   = 8;

    // back-pressure run, jump/jump/split/match on 'a'
    localparam logic [PC_WIDTH-1:0] BP_PC [FIFO_DEPTH] = '{8'd2, 8'd7, 8'd1, 8'd0};
    localparam int BP_OUTS = 5;
    localparam pc_entry_t BP_EXP [BP_OUTS] = '{
        '{8'd5, 1'b1},
        '{8'd0, 1'b1},
        '{8'd2, 1'b1},
        '{8'd4, 1'b1},
        '{8'd1, 1'b0}
    };

    logic                      clk;
    logic                      arst_n;
    pc_entry_t                 in_pc;
    logic                      in_pc_valid;
    logic                      in_pc_ready;
    pc_entry_t                 out_pc;
    logic                      out_pc_valid;
    logic                      out_pc_ready;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    logic                      mem_valid;
    logic [MEM_WIDTH-1:0]      mem_data;
    logic                      mem_ready;
    logic                      go;
    logic                      cur_is_even_character;
    logic [CHAR_WIDTH-1:0]     current_character;
    logic                      accepts;
    logic                      running;

    logic [MEM_WIDTH-1:0] imem [2**MEM_ADDR_WIDTH];
    integer               seed;
    int                   mem_wait;
    int                   out_wait;
    pc_entry_t            got_q [$];
    int                   accept_count;
    int                   mismatch_count;
    int                   timeout_count;

    basic_block dut (
        .clk                   (clk),
        .arst_n                (arst_n),
        .in_pc                 (in_pc),
        .in_pc_valid           (in_pc_valid),
        .in_pc_ready           (in_pc_ready),
        .out_pc                (out_pc),
        .out_pc_valid          (out_pc_valid),
        .out_pc_ready          (out_pc_ready),
        .mem_addr              (mem_addr),
        .mem_valid             (mem_valid),
        .mem_data              (mem_data),
        .mem_ready             (mem_ready),
        .go                    (go),
        .cur_is_even_character (cur_is_even_character),
        .current_character     (current_character),
        .accepts               (accepts),
        .running               (running)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // memory and sink responders
    ////////////////////////////////////////////////////////////
    // ready high at a falling edge means the rising edge before it transferred
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (mem_ready)
            begin
                mem_ready = 1'b0;
                mem_wait  = $unsigned($random(seed)) % 4;
            end
            else if (mem_valid)
            begin
                if (mem_wait == 0)
                begin
                    mem_ready = 1'b1;
                    mem_data  = imem[mem_addr];
                end
                else
                    mem_wait--;
            end

            // sink side, split keeps valid high for its second packet
            if (out_pc_ready)
            begin
                out_pc_ready = 1'b0;
                out_wait     = $unsigned($random(seed)) % 4;
            end
            else if (out_pc_valid)
            begin
                if (out_wait == 0)
                    out_pc_ready = 1'b1;
                else
                    out_wait--;
            end
        end
    end

    // collect transfers and accept pulses
    always @(posedge clk)
    begin
        if (arst_n)
        begin
            if (out_pc_valid && out_pc_ready)
                got_q.push_back(out_pc);
            if (accepts)
                accept_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            mismatch_count++;
        end
    endtask

    // called at a falling edge, returns at a falling edge with valid low
    task automatic inject_pc(input pc_entry_t entry);
        int waited;
        waited      = 0;
        in_pc       = entry;
        in_pc_valid = 1'b1;
        while (!in_pc_ready && waited < READY_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!in_pc_ready)
        begin
            $display("timeout: in_pc_ready never rose for pc 0x%0h", entry.pc);
            timeout_count++;
        end
        else
            @(posedge clk);
        @(negedge clk);
        in_pc_valid = 1'b0;
    endtask

    // one extra edge so the collector sees a late accepts pulse
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (running && waited < IDLE_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (running)
        begin
            $display("timeout: running did not fall after %0d cycles", IDLE_TIMEOUT);
            timeout_count++;
        end
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic apply_row(input tb_row_t row);
        got_q.delete();
        accept_count          = 0;
        go                    = 1'b1;
        cur_is_even_character = row.even;
        current_character     = row.character;
        inject_pc('{pc: row.pc, to_current: row.to_current});
        if (!row.to_current)
        begin
            // thread parked in the next queue, engine must stay quiet
            repeat (HOLD_CYCLES)
            begin
                @(negedge clk);
                check_value("mem_valid", mem_valid, 1'b0);
                check_value("running", running, 1'b0);
            end
            cur_is_even_character = !row.even;
        end
        wait_idle();
        check_value("out_pc_valid transfers", got_q.size(), row.n_out);
        if (got_q.size() > 0 && row.n_out > 0)
        begin
            check_value("out_pc.pc", got_q[0].pc, row.exp_first.pc);
            check_value("out_pc.to_current", got_q[0].to_current, row.exp_first.to_current);
        end
        if (got_q.size() > 1 && row.n_out > 1)
        begin
            check_value("out_pc.pc", got_q[1].pc, row.exp_second.pc);
            check_value("out_pc.to_current", got_q[1].to_current, row.exp_second.to_current);
        end
        check_value("accepts", accept_count, row.exp_accept);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        clk                   = 1'b0;
        arst_n                = 1'b0;
        in_pc                 = '0;
        in_pc_valid           = 1'b0;
        out_pc_ready          = 1'b0;
        mem_data              = '0;
        mem_ready             = 1'b0;
        go                    = 1'b0;
        cur_is_even_character = 1'b1;
        current_character     = '0;
        accept_count          = 0;
        mismatch_count        = 0;
        timeout_count         = 0;
        seed                  = 32'hf8b91e81;
        mem_wait              = $unsigned($random(seed)) % 4;
        out_wait              = $unsigned($random(seed)) % 4;

        // unused words decode as accept with the word address as operand
        for (int a = 0; a < 2**MEM_ADDR_WIDTH; a++)
            imem[a] = {2'b11, 7'd0, 7'(a), 2'b11, 7'd0, 7'(a)};
        for (int w = 0; w < TB_PROGRAM_WORDS; w++)
            imem[w] = TB_PROGRAM[w];

        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // state right after reset
        check_value("out_pc_valid", out_pc_valid, 1'b0);
        check_value("mem_valid", mem_valid, 1'b0);
        check_value("accepts", accepts, 1'b0);
        check_value("running", running, 1'b0);
        check_value("in_pc_ready", in_pc_ready, 1'b1);

        for (int r = 0; r < TB_ROWS; r++)
            apply_row(TB_TABLE[r]);

        // fill the current queue with the engine stopped
        got_q.delete();
        accept_count          = 0;
        go                    = 1'b0;
        cur_is_even_character = 1'b1;
        current_character     = 8'h61;
        for (int i = 0; i < FIFO_DEPTH; i++)
            inject_pc('{pc: BP_PC[i], to_current: 1'b1});
        check_value("in_pc_ready", in_pc_ready, 1'b0);
        check_value("mem_valid", mem_valid, 1'b0);

        // release, outputs must come back in input order
        go = 1'b1;
        wait_idle();
        check_value("out_pc_valid transfers", got_q.size(), BP_OUTS);
        for (int k = 0; k < BP_OUTS && k < got_q.size(); k++)
        begin
            check_value("out_pc.pc", got_q[k].pc, BP_EXP[k].pc);
            check_value("out_pc.to_current", got_q[k].to_current, BP_EXP[k].to_current);
        end
        check_value("accepts", accept_count, 0);
        check_value("in_pc_ready", in_pc_ready, 1'b1);

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
verilog/regex_pkg.sv
verilog/mem_pkg.sv
verilog/pc_fifo.sv
verilog/pc_store.sv
verilog/instr_fetch.sv
verilog/regex_cpu.sv
verilog/basic_block.sv
test/tb_basic_block.sv
